//--- Makefile
# Verilator build and run of the stream-register testbench.

TOP := ssr_streamer_tb

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

//--- logic/ssr_addr_gen.sv
/*
 * Configuration registers and two-level address loop of one lane.
 * Address sequence is base + i*stride0 + j*stride1, inner index i.
 */

`default_nettype none

module ssr_addr_gen (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              cfg_write_i,
  input  ssr_cfg_pkg::cfg_word_t            cfg_word_i,
  input  ssr_cfg_pkg::cfg_data_t            cfg_wdata_i,
  output ssr_cfg_pkg::cfg_data_t            cfg_rdata_o,
  output logic                              cfg_wready_o,
  input  logic                              drained_i,
  output logic [ssr_cfg_pkg::RptWidth-1:0]  rep_o,
  output logic                              write_o,
  output ssr_mem_pkg::addr_t                addr_o,
  output logic                              valid_o,
  input  logic                              ready_i
);
  import ssr_cfg_pkg::*;
  import ssr_mem_pkg::*;

  logic [RptWidth-1:0]   rep_q;
  logic [BoundWidth-1:0] bound0_q, bound1_q;
  logic [BoundWidth-1:0] cnt0_q, cnt1_q;
  addr_t                 stride0_q, stride1_q;
  addr_t                 base_q, addr_q;
  logic                  busy_q, valid_q, write_q;
  logic                  cfg_we, launch, step, inner_wrap, last;

  // No register changes while a job runs.
  assign cfg_we     = cfg_write_i & ~busy_q;
  assign launch     = cfg_we & ((cfg_word_i == RegRptr) | (cfg_word_i == RegWptr));
  assign step       = valid_q & ready_i;
  assign inner_wrap = (cnt0_q == bound0_q);
  assign last       = inner_wrap & (cnt1_q == bound1_q);

  assign cfg_wready_o = ~busy_q;
  assign rep_o        = rep_q;
  assign write_o      = write_q;
  assign addr_o       = addr_q;
  assign valid_o      = valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rep_q     <= '0;
      bound0_q  <= '0;
      bound1_q  <= '0;
      stride0_q <= '0;
      stride1_q <= '0;
      cnt0_q    <= '0;
      cnt1_q    <= '0;
      busy_q    <= 1'b0;
      valid_q   <= 1'b0;
      write_q   <= 1'b0;
    end else begin
      if (cfg_we) begin
        case (cfg_word_i)
          RegRepeat:  rep_q     <= cfg_wdata_i[RptWidth-1:0];
          RegBound0:  bound0_q  <= cfg_wdata_i[BoundWidth-1:0];
          RegBound1:  bound1_q  <= cfg_wdata_i[BoundWidth-1:0];
          RegStride0: stride0_q <= addr_t'(cfg_wdata_i);
          RegStride1: stride1_q <= addr_t'(cfg_wdata_i);
          default: ;
        endcase
      end
      if (launch) begin
        busy_q  <= 1'b1;
        valid_q <= 1'b1;
        write_q <= (cfg_word_i == RegWptr);
        cnt0_q  <= '0;
        cnt1_q  <= '0;
      end else if (step) begin
        if (inner_wrap) begin
          cnt0_q <= '0;
          cnt1_q <= cnt1_q + 1'b1;
        end else begin
          cnt0_q <= cnt0_q + 1'b1;
        end
        if (last) begin
          valid_q <= 1'b0;
        end
      end else if (busy_q && !valid_q && drained_i) begin
        // Loop is done and every credit is back.
        busy_q <= 1'b0;
      end
    end
  end

  // Row base follows the outer loop; the address follows the inner one.
  always_ff @(posedge clk_i) begin
    if (launch) begin
      base_q <= addr_t'(cfg_wdata_i);
      addr_q <= addr_t'(cfg_wdata_i);
    end else if (step) begin
      if (inner_wrap) begin
        base_q <= base_q + stride1_q;
        addr_q <= base_q + stride1_q;
      end else begin
        addr_q <= addr_q + stride0_q;
      end
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_word_i)
      RegStatus:        cfg_rdata_o[0] = busy_q;
      RegRepeat:        cfg_rdata_o = cfg_data_t'(rep_q);
      RegBound0:        cfg_rdata_o = cfg_data_t'(bound0_q);
      RegBound1:        cfg_rdata_o = cfg_data_t'(bound1_q);
      RegStride0:       cfg_rdata_o = cfg_data_t'(stride0_q);
      RegStride1:       cfg_rdata_o = cfg_data_t'(stride1_q);
      RegRptr, RegWptr: cfg_rdata_o = cfg_data_t'(addr_q);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/ssr_cfg_demux.sv
/*
 * Configuration decoder: one write strobe per lane, and
 * read-back data and write-ready of the selected lane.
 */

`default_nettype none

module ssr_cfg_demux (
  input  logic                    cfg_valid_i,
  input  ssr_cfg_pkg::lane_idx_t  cfg_lane_i,
  input  logic                    cfg_write_i,
  output logic                    lane_write_o  [ssr_cfg_pkg::NumLanes],
  input  ssr_cfg_pkg::cfg_data_t  lane_rdata_i  [ssr_cfg_pkg::NumLanes],
  input  logic                    lane_wready_i [ssr_cfg_pkg::NumLanes],
  output ssr_cfg_pkg::cfg_data_t  cfg_rdata_o,
  output logic                    cfg_wready_o
);
  import ssr_cfg_pkg::*;

  always_comb begin
    cfg_rdata_o  = '0;
    cfg_wready_o = 1'b0;
    for (int unsigned n = 0; n < NumLanes; n++) begin
      lane_write_o[n] = cfg_valid_i & cfg_write_i & (cfg_lane_i == lane_idx_t'(n));
      if (cfg_lane_i == lane_idx_t'(n)) begin
        cfg_rdata_o  = lane_rdata_i[n];
        cfg_wready_o = lane_wready_i[n];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ssr_cfg_pkg.sv
/*
 * Lane count, counter widths, credit depth and the
 * configuration register map of the streamer lanes.
 */

`default_nettype none

package ssr_cfg_pkg;

  localparam int unsigned NumLanes     = 2;
  localparam int unsigned LaneIdxWidth = (NumLanes > 1) ? $clog2(NumLanes) : 1;
  typedef logic [LaneIdxWidth-1:0] lane_idx_t;

  // Data FIFO depth per lane; also the number of credits.
  localparam int unsigned DataCredits    = 4;
  localparam int unsigned CreditWidth    = $clog2(DataCredits + 1);
  localparam int unsigned MaxOutstanding = NumLanes * DataCredits;

  localparam int unsigned BoundWidth = 8;
  localparam int unsigned RptWidth   = 4;

  typedef logic [4:0]  cfg_word_t;
  typedef logic [31:0] cfg_data_t;

  // Register words. Bounds hold the iteration count minus one.
  localparam cfg_word_t RegStatus  = 5'd0;
  localparam cfg_word_t RegRepeat  = 5'd1;
  localparam cfg_word_t RegBound0  = 5'd2;
  localparam cfg_word_t RegBound1  = 5'd3;
  localparam cfg_word_t RegStride0 = 5'd4;
  localparam cfg_word_t RegStride1 = 5'd5;
  localparam cfg_word_t RegRptr    = 5'd6;
  localparam cfg_word_t RegWptr    = 5'd7;

endpackage

`default_nettype wire

//--- logic/ssr_fifo.sv
/*
 * Registered FIFO, not fall-through, with a type-parameter payload.
 * Push while full and pop while empty are ignored.
 */

`default_nettype none

module ssr_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                do_push, do_pop;

  assign full_o  = (count_q == (PtrWidth + 1)'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push != do_pop) begin
        count_q <= do_push ? count_q + 1'b1 : count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/ssr_lane.sv
/*
 * One streamer lane: address generator, data FIFO, credit counter,
 * repetition counter and read/write direction control.
 */

`default_nettype none

module ssr_lane (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cfg_write_i,
  input  ssr_cfg_pkg::cfg_word_t  cfg_word_i,
  input  ssr_cfg_pkg::cfg_data_t  cfg_wdata_i,
  output ssr_cfg_pkg::cfg_data_t  cfg_rdata_o,
  output logic                    cfg_wready_o,
  output ssr_mem_pkg::data_t      lane_rdata_o,
  input  ssr_mem_pkg::data_t      lane_wdata_i,
  output logic                    lane_valid_o,
  input  logic                    lane_ready_i,
  output logic                    req_valid_o,
  input  logic                    req_ready_i,
  output ssr_mem_pkg::addr_t      req_addr_o,
  output logic                    req_write_o,
  output ssr_mem_pkg::data_t      req_wdata_o,
  input  logic                    rsp_valid_i,
  input  ssr_mem_pkg::data_t      rsp_rdata_i
);
  import ssr_cfg_pkg::*;
  import ssr_mem_pkg::*;

  data_t                fifo_in, fifo_out;
  logic                 fifo_push, fifo_pop, fifo_full, fifo_empty;
  logic [CreditWidth-1:0] credit_q;
  logic                 has_credit, credit_full, credit_take, credit_give;
  logic [RptWidth-1:0]  rep_max, rep_q;
  logic                 rep_enable, rep_done;
  logic                 agen_valid, agen_ready, agen_write;

  ssr_addr_gen i_addr_gen (
    .clk_i,
    .rst_n_i,
    .cfg_write_i,
    .cfg_word_i,
    .cfg_wdata_i,
    .cfg_rdata_o,
    .cfg_wready_o,
    .drained_i    ( credit_full & fifo_empty ),
    .rep_o        ( rep_max    ),
    .write_o      ( agen_write ),
    .addr_o       ( req_addr_o ),
    .valid_o      ( agen_valid ),
    .ready_i      ( agen_ready )
  );

  ssr_fifo #(
    .payload_t ( data_t      ),
    .Depth     ( DataCredits )
  ) i_fifo (
    .clk_i,
    .rst_n_i,
    .push_i  ( fifo_push  ),
    .data_i  ( fifo_in    ),
    .pop_i   ( fifo_pop   ),
    .data_o  ( fifo_out   ),
    .full_o  ( fifo_full  ),
    .empty_o ( fifo_empty )
  );

  assign agen_ready   = req_valid_o & req_ready_i;
  assign req_write_o  = agen_write;
  // Read requests carry no data, so a stalled request stays stable.
  assign req_wdata_o  = agen_write ? fifo_out : '0;
  assign lane_rdata_o = fifo_out;

  always_comb begin
    if (agen_write) begin
      // In write direction the producer fills the FIFO and memory drains it.
      lane_valid_o = ~fifo_full;
      req_valid_o  = agen_valid & ~fifo_empty & has_credit;
      fifo_push    = lane_ready_i & ~fifo_full;
      fifo_in      = lane_wdata_i;
      rep_enable   = 1'b0;
      fifo_pop     = req_valid_o & req_ready_i;
      credit_take  = fifo_pop;
      credit_give  = rsp_valid_i;
    end else begin
      // In read direction a credit reserves a FIFO slot for each response.
      lane_valid_o = ~fifo_empty;
      req_valid_o  = agen_valid & has_credit;
      fifo_push    = rsp_valid_i;
      fifo_in      = rsp_rdata_i;
      rep_enable   = lane_ready_i & lane_valid_o;
      fifo_pop     = rep_enable & rep_done;
      credit_take  = req_valid_o & req_ready_i;
      credit_give  = rep_enable & rep_done;
    end
  end

  // Free credits start full at reset.
  assign has_credit  = (credit_q != '0);
  assign credit_full = (credit_q == CreditWidth'(DataCredits));
  assign rep_done    = (rep_q == rep_max);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= CreditWidth'(DataCredits);
      rep_q    <= '0;
    end else begin
      if (credit_give != credit_take) begin
        credit_q <= credit_give ? credit_q + 1'b1 : credit_q - 1'b1;
      end
      if (rep_enable) begin
        rep_q <= rep_done ? '0 : rep_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ssr_mem_arbiter.sv
/*
 * Round-robin arbiter from the lanes onto one memory port.
 * An owner FIFO records grants in order and steers responses back.
 */

`default_nettype none

module ssr_mem_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i [ssr_cfg_pkg::NumLanes],
  output logic                req_ready_o [ssr_cfg_pkg::NumLanes],
  input  ssr_mem_pkg::addr_t  req_addr_i  [ssr_cfg_pkg::NumLanes],
  input  logic                req_write_i [ssr_cfg_pkg::NumLanes],
  input  ssr_mem_pkg::data_t  req_wdata_i [ssr_cfg_pkg::NumLanes],
  output logic                rsp_valid_o [ssr_cfg_pkg::NumLanes],
  output ssr_mem_pkg::data_t  rsp_rdata_o [ssr_cfg_pkg::NumLanes],
  output logic                mem_q_valid_o,
  input  logic                mem_q_ready_i,
  output ssr_mem_pkg::addr_t  mem_q_addr_o,
  output logic                mem_q_write_o,
  output ssr_mem_pkg::data_t  mem_q_wdata_o,
  input  logic                mem_p_valid_i,
  input  ssr_mem_pkg::data_t  mem_p_rdata_i
);
  import ssr_cfg_pkg::*;
  import ssr_mem_pkg::*;

  lane_idx_t rr_q, grant, grant_next, own_head;
  logic      found, own_full, own_empty, accept;

  // First requesting lane at or after the pointer.
  always_comb begin
    int unsigned cand;
    grant = rr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < NumLanes; k++) begin
      cand = (rr_q + k) % NumLanes;
      if (!found && req_valid_i[cand]) begin
        grant = lane_idx_t'(cand);
        found = 1'b1;
      end
    end
  end

  assign mem_q_valid_o = found & ~own_full;
  assign mem_q_addr_o  = req_addr_i[grant];
  assign mem_q_write_o = req_write_i[grant];
  assign mem_q_wdata_o = req_wdata_i[grant];
  assign accept        = mem_q_valid_o & mem_q_ready_i;
  assign grant_next    = lane_idx_t'((grant + 1) % NumLanes);

  always_comb begin
    for (int unsigned n = 0; n < NumLanes; n++) begin
      req_ready_o[n] = mem_q_ready_i & mem_q_valid_o & (grant == lane_idx_t'(n));
      rsp_valid_o[n] = mem_p_valid_i & ~own_empty & (own_head == lane_idx_t'(n));
      rsp_rdata_o[n] = mem_p_rdata_i;
    end
  end

  // A stalled grant parks the pointer on itself, so the request stays put.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (mem_q_valid_o) begin
      rr_q <= mem_q_ready_i ? grant_next : grant;
    end
  end

  ssr_fifo #(
    .payload_t ( lane_idx_t     ),
    .Depth     ( MaxOutstanding )
  ) i_owner_fifo (
    .clk_i,
    .rst_n_i,
    .push_i  ( accept        ),
    .data_i  ( grant         ),
    .pop_i   ( mem_p_valid_i ),
    .data_o  ( own_head      ),
    .full_o  ( own_full      ),
    .empty_o ( own_empty     )
  );

endmodule

`default_nettype wire

//--- logic/ssr_mem_pkg.sv
/*
 * Memory-side widths and types for the stream-register subsystem.
 * Addresses count words, not bytes.
 */

`default_nettype none

package ssr_mem_pkg;

  // Word-address width of the memory port.
  localparam int unsigned AddrWidth = 16;

  // Width of one data word.
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

endpackage

`default_nettype wire

//--- logic/ssr_streamer.sv
/*
 * Stream-register top: configuration decoder, the lanes and
 * the memory arbiter.
 */

`default_nettype none

module ssr_streamer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cfg_valid_i,
  input  ssr_cfg_pkg::lane_idx_t  cfg_lane_i,
  input  ssr_cfg_pkg::cfg_word_t  cfg_word_i,
  input  logic                    cfg_write_i,
  input  ssr_cfg_pkg::cfg_data_t  cfg_wdata_i,
  output ssr_cfg_pkg::cfg_data_t  cfg_rdata_o,
  output logic                    cfg_wready_o,
  output ssr_mem_pkg::data_t      lane_rdata_o [ssr_cfg_pkg::NumLanes],
  input  ssr_mem_pkg::data_t      lane_wdata_i [ssr_cfg_pkg::NumLanes],
  output logic                    lane_valid_o [ssr_cfg_pkg::NumLanes],
  input  logic                    lane_ready_i [ssr_cfg_pkg::NumLanes],
  output logic                    mem_q_valid_o,
  input  logic                    mem_q_ready_i,
  output ssr_mem_pkg::addr_t      mem_q_addr_o,
  output logic                    mem_q_write_o,
  output ssr_mem_pkg::data_t      mem_q_wdata_o,
  input  logic                    mem_p_valid_i,
  input  ssr_mem_pkg::data_t      mem_p_rdata_i
);
  import ssr_cfg_pkg::*;
  import ssr_mem_pkg::*;

  logic      lane_cfg_write  [NumLanes];
  cfg_data_t lane_cfg_rdata  [NumLanes];
  logic      lane_cfg_wready [NumLanes];
  logic      req_valid [NumLanes];
  logic      req_ready [NumLanes];
  addr_t     req_addr  [NumLanes];
  logic      req_write [NumLanes];
  data_t     req_wdata [NumLanes];
  logic      rsp_valid [NumLanes];
  data_t     rsp_rdata [NumLanes];

  ssr_cfg_demux i_cfg_demux (
    .cfg_valid_i,
    .cfg_lane_i,
    .cfg_write_i,
    .lane_write_o  ( lane_cfg_write  ),
    .lane_rdata_i  ( lane_cfg_rdata  ),
    .lane_wready_i ( lane_cfg_wready ),
    .cfg_rdata_o,
    .cfg_wready_o
  );

  for (genvar n = 0; n < NumLanes; n++) begin : gen_lane
    ssr_lane i_lane (
      .clk_i,
      .rst_n_i,
      .cfg_write_i  ( lane_cfg_write[n]  ),
      .cfg_word_i,
      .cfg_wdata_i,
      .cfg_rdata_o  ( lane_cfg_rdata[n]  ),
      .cfg_wready_o ( lane_cfg_wready[n] ),
      .lane_rdata_o ( lane_rdata_o[n]    ),
      .lane_wdata_i ( lane_wdata_i[n]    ),
      .lane_valid_o ( lane_valid_o[n]    ),
      .lane_ready_i ( lane_ready_i[n]    ),
      .req_valid_o  ( req_valid[n]       ),
      .req_ready_i  ( req_ready[n]       ),
      .req_addr_o   ( req_addr[n]        ),
      .req_write_o  ( req_write[n]       ),
      .req_wdata_o  ( req_wdata[n]       ),
      .rsp_valid_i  ( rsp_valid[n]       ),
      .rsp_rdata_i  ( rsp_rdata[n]       )
    );
  end

  ssr_mem_arbiter i_mem_arbiter (
    .clk_i,
    .rst_n_i,
    .req_valid_i ( req_valid ),
    .req_ready_o ( req_ready ),
    .req_addr_i  ( req_addr  ),
    .req_write_i ( req_write ),
    .req_wdata_i ( req_wdata ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_rdata_o ( rsp_rdata ),
    .mem_q_valid_o,
    .mem_q_ready_i,
    .mem_q_addr_o,
    .mem_q_write_o,
    .mem_q_wdata_o,
    .mem_p_valid_i,
    .mem_p_rdata_i
  );

endmodule

`default_nettype wire

//--- sim/ssr_streamer_chk.sv
/*
 * Assertions bound into the streamer top: memory request stability,
 * lane state after reset and no response without a request.
 */

`default_nettype none

module ssr_streamer_chk (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               lane_valid_o [ssr_cfg_pkg::NumLanes],
  input logic               mem_q_valid_o,
  input logic               mem_q_ready_i,
  input ssr_mem_pkg::addr_t mem_q_addr_o,
  input logic               mem_q_write_o,
  input ssr_mem_pkg::data_t mem_q_wdata_o,
  input logic               mem_p_valid_i
);
  import ssr_cfg_pkg::*;

  int outstanding;

  // Requests accepted by memory and not yet answered.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(mem_q_valid_o && mem_q_ready_i) - int'(mem_p_valid_i);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_q_valid_o && !mem_q_ready_i |=>
      $stable(mem_q_addr_o) && $stable(mem_q_write_o) && $stable(mem_q_wdata_o))
    else $error("memory request changed while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) mem_p_valid_i |-> outstanding != 0)
    else $error("memory response with no request outstanding");

  for (genvar n = 0; n < NumLanes; n++) begin : gen_rst
    // Lanes come out of reset in read direction with an empty FIFO.
    assert property (@(posedge clk_i) !rst_n_i |=> !lane_valid_o[n])
      else $error("lane valid high right after reset");
  end

endmodule

bind ssr_streamer ssr_streamer_chk u_chk (.*);

`default_nettype wire

//--- sim/ssr_streamer_tb.sv
/*
 * Testbench for the stream-register top: clock, reset, memory model,
 * job table, lane drivers and checks of streams, memory and registers.
 */

`default_nettype none

module ssr_streamer_tb;
  import ssr_cfg_pkg::*;
  import ssr_mem_pkg::*;

  typedef struct packed {
    int lane;
    bit wr;
    int ptr;
    int b0;
    int b1;
    int s0;
    int s1;
    int rpt;
    bit bp;
    bit par;
  } job_t;

  localparam int NumJobs = 7;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic cfg_valid_i, cfg_write_i, cfg_wready_o;
  lane_idx_t cfg_lane_i;
  cfg_word_t cfg_word_i;
  cfg_data_t cfg_wdata_i, cfg_rdata_o;
  data_t lane_rdata_o [NumLanes];
  data_t lane_wdata_i [NumLanes];
  logic  lane_valid_o [NumLanes];
  logic  lane_ready_i [NumLanes];
  logic  mem_q_valid_o, mem_q_ready_i, mem_q_write_o, mem_p_valid_i;
  addr_t mem_q_addr_o;
  data_t mem_q_wdata_o, mem_p_rdata_i;

  job_t  jobs [NumJobs];
  data_t mem [65536];
  data_t ref_mem [65536];
  data_t exp_data [NumLanes][256];
  int    exp_cnt [NumLanes];
  int    xfer_idx [NumLanes];
  bit    active [NumLanes];
  bit    is_wr [NumLanes];
  bit    bp_on;
  int    seed = 32'hda400ecf;
  int    errors;
  int    wd_limit;
  int    cyc, mem_due, last_due;
  data_t rsp_q [$];
  int    due_q [$];

  ssr_streamer u_dut (.*);

  always #4 clk_i = ~clk_i;

  // Preload pattern that differs for every word address.
  function automatic data_t fill_word(int a);
    return {16'(a) ^ 16'h3c96, 16'(a)};
  endfunction

  function automatic addr_t elem_addr(int r, int i, int j);
    return addr_t'(jobs[r].ptr + i * jobs[r].s0 + j * jobs[r].s1);
  endfunction

  // Memory model with in-order responses 1 to 3 cycles after acceptance.
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (!rst_n_i) begin
      mem_p_valid_i <= 1'b0;
      mem_q_ready_i <= 1'b0;
    end else begin
      if (mem_q_valid_o && mem_q_ready_i) begin
        if (mem_q_write_o) begin
          mem[mem_q_addr_o] = mem_q_wdata_o;
        end
        mem_due = cyc + 1 + (($random(seed) & 255) % 3);
        if (mem_due <= last_due) begin
          mem_due = last_due + 1;
        end
        last_due = mem_due;
        rsp_q.push_back(mem_q_write_o ? '0 : mem[mem_q_addr_o]);
        due_q.push_back(mem_due);
      end
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        mem_p_valid_i <= 1'b1;
        mem_p_rdata_i <= rsp_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        mem_p_valid_i <= 1'b0;
      end
      mem_q_ready_i <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  // Lane drivers consume read streams and feed write streams.
  always @(posedge clk_i) begin
    for (int n = 0; n < NumLanes; n++) begin
      if (lane_valid_o[n] && lane_ready_i[n]) begin
        if (!active[n]) begin
          errors++;
          $display("Lane %0d moved a word with no job running", n);
        end else begin
          if (!is_wr[n] && lane_rdata_o[n] !== exp_data[n][xfer_idx[n]]) begin
            errors++;
            $display("ERR lane_rdata_o[%0d] exp %h got %h", n,
                     exp_data[n][xfer_idx[n]], lane_rdata_o[n]);
          end
          xfer_idx[n]++;
        end
      end
      if (active[n] && xfer_idx[n] < exp_cnt[n]) begin
        lane_ready_i[n] <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
        lane_wdata_i[n] <= exp_data[n][xfer_idx[n]];
      end else begin
        lane_ready_i[n] <= 1'b0;
      end
    end
  end

  task automatic cfg_write(int lane, cfg_word_t word, cfg_data_t data);
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_write_i <= 1'b1;
    cfg_lane_i  <= lane_idx_t'(lane);
    cfg_word_i  <= word;
    cfg_wdata_i <= data;
    do @(posedge clk_i); while (!cfg_wready_o);
    cfg_valid_i <= 1'b0;
    cfg_write_i <= 1'b0;
  endtask

  task automatic cfg_read(int lane, cfg_word_t word, output cfg_data_t data, output logic rdy);
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_lane_i  <= lane_idx_t'(lane);
    cfg_word_i  <= word;
    @(posedge clk_i);
    data = cfg_rdata_o;
    rdy  = cfg_wready_o;
    cfg_valid_i <= 1'b0;
  endtask

  // The lane is idle here, so it must also accept writes.
  task automatic check_reg(int lane, cfg_word_t word, cfg_data_t exp);
    cfg_data_t d;
    logic      rdy;
    cfg_read(lane, word, d, rdy);
    if (d !== exp) begin
      errors++;
      $display("ERR cfg_rdata_o word %h exp %h got %h", word, exp, d);
    end
    if (rdy !== 1'b1) begin
      errors++;
      $display("ERR cfg_wready_o exp 1 got %h", rdy);
    end
  endtask

  task automatic start_job(int r);
    int        ln;
    int        k;
    cfg_data_t d;
    logic      rdy;
    ln = jobs[r].lane;
    k  = 0;
    bp_on = jobs[r].bp;
    for (int j = 0; j <= jobs[r].b1; j++) begin
      for (int i = 0; i <= jobs[r].b0; i++) begin
        if (jobs[r].wr) begin
          exp_data[ln][k] = $random(seed);
          ref_mem[elem_addr(r, i, j)] = exp_data[ln][k];
          k++;
        end else begin
          repeat (jobs[r].rpt + 1) begin
            exp_data[ln][k] = ref_mem[elem_addr(r, i, j)];
            k++;
          end
        end
      end
    end
    exp_cnt[ln]  = k;
    xfer_idx[ln] = 0;
    is_wr[ln]    = jobs[r].wr;
    cfg_write(ln, RegRepeat, jobs[r].rpt);
    cfg_write(ln, RegBound0, jobs[r].b0);
    cfg_write(ln, RegBound1, jobs[r].b1);
    cfg_write(ln, RegStride0, jobs[r].s0);
    cfg_write(ln, RegStride1, jobs[r].s1);
    check_reg(ln, RegRepeat, jobs[r].rpt);
    check_reg(ln, RegBound0, jobs[r].b0);
    check_reg(ln, RegBound1, jobs[r].b1);
    check_reg(ln, RegStride0, jobs[r].s0);
    check_reg(ln, RegStride1, jobs[r].s1);
    cfg_write(ln, jobs[r].wr ? RegWptr : RegRptr, jobs[r].ptr);
    active[ln] = 1'b1;
    cfg_read(ln, RegStatus, d, rdy);
    if (d[0] !== 1'b1) begin
      errors++;
      $display("ERR cfg_rdata_o busy exp 1 got %h", d[0]);
    end
    if (rdy !== 1'b0) begin
      errors++;
      $display("ERR cfg_wready_o exp 0 got %h", rdy);
    end
  endtask

  task automatic finish_job(int r);
    int        ln;
    addr_t     a;
    cfg_data_t d;
    logic      rdy;
    ln = jobs[r].lane;
    do cfg_read(ln, RegStatus, d, rdy); while (d[0]);
    if (rdy !== 1'b1) begin
      errors++;
      $display("ERR cfg_wready_o exp 1 got %h", rdy);
    end
    active[ln] = 1'b0;
    if (xfer_idx[ln] != exp_cnt[ln]) begin
      errors++;
      $display("Job %0d moved %0d of %0d words", r, xfer_idx[ln], exp_cnt[ln]);
    end
    if (jobs[r].wr) begin
      for (int j = 0; j <= jobs[r].b1; j++) begin
        for (int i = 0; i <= jobs[r].b0; i++) begin
          a = elem_addr(r, i, j);
          if (mem[a] !== ref_mem[a]) begin
            errors++;
            $display("ERR mem[%h] exp %h got %h", a, ref_mem[a], mem[a]);
          end
        end
      end
    end
  endtask

  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a job never finished", wd_limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int i;
    rst_n_i     <= 1'b0;
    cfg_valid_i <= 1'b0;
    cfg_write_i <= 1'b0;
    cfg_lane_i  <= '0;
    cfg_word_i  <= '0;
    cfg_wdata_i <= '0;
    mem_q_ready_i <= 1'b0;
    mem_p_valid_i <= 1'b0;
    mem_p_rdata_i <= '0;
    for (int n = 0; n < NumLanes; n++) begin
      lane_wdata_i[n] <= '0;
      lane_ready_i[n] <= 1'b0;
    end
    // Each row holds lane, wr, ptr, bound0, bound1, stride0, stride1, repeat, bp and parallel.
    jobs[0] = '{0, 1'b0, 32'h0100, 3, 2, 1, 16, 0, 1'b0, 1'b0};
    jobs[1] = '{0, 1'b0, 32'h0200, 2, 1, 2, 32, 2, 1'b1, 1'b0};
    jobs[2] = '{1, 1'b1, 32'h0300, 4, 1, 1, 8, 0, 1'b0, 1'b0};
    jobs[3] = '{0, 1'b0, 32'h0400, 5, 2, 3, 40, 1, 1'b1, 1'b1};
    jobs[4] = '{1, 1'b1, 32'h0500, 3, 3, 1, 4, 0, 1'b1, 1'b0};
    jobs[5] = '{1, 1'b1, 32'h0600, 3, 1, 1, 4, 0, 1'b1, 1'b0};
    jobs[6] = '{1, 1'b0, 32'h0600, 3, 1, 1, 4, 0, 1'b1, 1'b0};
    for (int a = 0; a < 65536; a++) begin
      mem[a]     = fill_word(a);
      ref_mem[a] = mem[a];
    end
    // Configuration and polling add a fixed share per job.
    wd_limit = 8;
    for (int r = 0; r < NumJobs; r++) begin
      wd_limit += (jobs[r].b0 + 1) * (jobs[r].b1 + 1) * (jobs[r].rpt + 1) * 20 + 60;
    end
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    i = 0;
    while (i < NumJobs) begin
      start_job(i);
      if (jobs[i].par) begin
        start_job(i + 1);
        finish_job(i);
        finish_job(i + 1);
        i += 2;
      end else begin
        finish_job(i);
        i++;
      end
    end
    $display("Jobs done with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/ssr_mem_pkg.sv
logic/ssr_cfg_pkg.sv
logic/ssr_fifo.sv
logic/ssr_addr_gen.sv
logic/ssr_lane.sv
logic/ssr_cfg_demux.sv
logic/ssr_mem_arbiter.sv
logic/ssr_streamer.sv
sim/ssr_streamer_chk.sv
sim/ssr_streamer_tb.sv
